// ==== files.f ====
+incdir+.
rv_isa_pkg.sv
rv_pipe_pkg.sv
rv_stage_reg.sv
rv_regfile.sv
rv_decoder.sv
rv_hazard_unit.sv
rv_execute.sv
rv_core.sv
rv_core_sva.sv
rv_core_tb.sv

// ==== rv_core_golden.txt ====
# P <word address hex> <instruction hex>
# R <pc hex> <rd_wren> <rd hex> <rd_data hex>, rd and data ignored without rd_wren
P 00 00500093
P 01 FFD00113
P 02 002081B3
P 03 40118233
P 04 123452B7
P 05 00001317
P 06 001123B3
P 07 00113433
P 08 00402423
P 09 00802483
P 0A 00148533
P 0B 00700013
P 0C 001005B3
P 0D 00B18463
P 0E 00B19663
P 0F 00100613
P 10 00100613
P 11 00114463
P 12 00100613
P 13 0020D463
P 14 00100613
P 15 0020E463
P 16 00100613
P 17 00117463
P 18 00100613
P 19 00318463
P 1A 00100613
P 1B 008006EF
P 1C 00100613
P 1D 00D68767
P 1E 00100613
P 1F 40115793
P 20 0000006F
P 21 00000013
P 22 00000013
R 00000000 1 01 00000005
R 00000004 1 02 FFFFFFFD
R 00000008 1 03 00000002
R 0000000C 1 04 FFFFFFFD
R 00000010 1 05 12345000
R 00000014 1 06 00001014
R 00000018 1 07 00000001
R 0000001C 1 08 00000000
R 00000020 0 00 00000000
R 00000024 1 09 FFFFFFFD
R 00000028 1 0A 00000002
R 0000002C 0 00 00000000
R 00000030 1 0B 00000005
R 00000034 0 00 00000000
R 00000038 0 00 00000000
R 00000044 0 00 00000000
R 0000004C 0 00 00000000
R 00000054 0 00 00000000
R 0000005C 0 00 00000000
R 00000064 0 00 00000000
R 0000006C 1 0D 00000070
R 00000074 1 0E 00000078
R 0000007C 1 0F FFFFFFFE
R 00000080 0 00 00000000

// ==== rv_core_tb.sv ====
`timescale 1ns/1ns

module rv_core_tb;
    import rv_pipe_pkg::*;

    logic     i_clk;
    logic     i_reset;
    prog_wr_t i_prog;
    retire_t  o_retire;

    prog_wr_t prog_q [$];
    retire_t  exp_q [$];
    int       exp_idx;
    int       cycle_count;
    int       cycle_limit;
    logic     run_started;

    rv_core i_rv_core (
        .i_clk(i_clk),
        .i_reset(i_reset),
        .i_prog(i_prog),
        .o_retire(o_retire)
    );

    initial begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;
    end

    ////////////////////
    // Golden file parsing
    task automatic read_golden();
        int          fd;
        int          n;
        string       line;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        prog_wr_t    p;
        retire_t     r;
        fd = $fopen("rv_core_golden.txt", "r");
        if (fd == 0) begin
            $display("Could not open the golden file rv_core_golden.txt");
            $display("Simulation failed");
            $fatal(1);
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line[0] == "P") begin // Program word
                n = $sscanf(line, "P %h %h", a, b);
                p.valid = 1'b1;
                p.addr  = a[7:0];
                p.instr = b;
                prog_q.push_back(p);
            end else if (n > 0 && line[0] == "R") begin
                n = $sscanf(line, "R %h %h %h %h", a, b, c, d);
                r.valid   = 1'b1;
                r.pc      = a;
                r.rd_wren = b[0];
                r.rd      = c[4:0];
                r.rd_data = d;
                exp_q.push_back(r);
            end
        end
        $fclose(fd);
    endtask

    // rd and data only matter when a register is written
    task automatic check_retire(input retire_t got, input retire_t exp, input int idx);
        if (got.pc !== exp.pc || got.rd_wren !== exp.rd_wren ||
            (exp.rd_wren && (got.rd !== exp.rd || got.rd_data !== exp.rd_data))) begin
            $display("Error at %0t ns: retirement %0d got pc %h wren %b rd %0d data %h",
                     $time, idx, got.pc, got.rd_wren, got.rd, got.rd_data);
            $display("    expected pc %h wren %b rd %0d data %h",
                     exp.pc, exp.rd_wren, exp.rd, exp.rd_data);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    ////////////////////
    // Stimulus
    initial begin
        i_reset     = 1'b1;
        i_prog      = '0;
        exp_idx     = 0;
        cycle_count = 0;
        run_started = 1'b0;
        read_golden();
        cycle_limit = 8 * exp_q.size() + 100;
        foreach (prog_q[i]) begin // One word per cycle under reset
            @(posedge i_clk);
            #1 i_prog = prog_q[i];
        end
        @(posedge i_clk);
        #1 i_prog = '0;
        repeat (8) @(posedge i_clk);
        #1 i_reset = 1'b0;
        run_started = 1'b1;
    end

    // Sampled mid-cycle away from the clock edge
    always @(negedge i_clk) begin
        if (i_rv_core.i_rv_core_sva.fail_count != 0) begin
            $display("An assertion on the core failed, see the assertion error above");
            $display("Simulation failed");
            $fatal(1);
        end else if (run_started) begin
            cycle_count++;
            if (o_retire.valid && exp_idx < exp_q.size()) begin
                check_retire(o_retire, exp_q[exp_idx], exp_idx);
                exp_idx++;
            end
            if (exp_idx == exp_q.size()) begin
                $display("Simulation passed");
                $finish;
            end else if (cycle_count >= cycle_limit) begin
                $display("Timeout after %0d cycles, only %0d of %0d retirements seen",
                         cycle_count, exp_idx, exp_q.size());
                $display("Simulation failed");
                $fatal(1);
            end
        end
    end

endmodule

// ==== rv_core_sva.sv ====
`timescale 1ns/1ns

module rv_core_sva (
    input logic                 i_clk,
    input logic                 i_reset,
    input rv_pipe_pkg::retire_t i_retire,
    input logic                 i_load_stall
);

    int fail_count = 0; // Failed assertions so far

    // Nothing retires in reset or on the cycle right after it
    assert property (@(posedge i_clk) i_reset |=> !i_retire.valid)
        else begin
            $error("retirement seen during or just after reset");
            fail_count++;
        end

    assert property (@(posedge i_clk) disable iff (i_reset)
        (i_retire.valid && i_retire.rd == '0) |-> !i_retire.rd_wren)
        else begin
            $error("retirement to x0 carries a register write");
            fail_count++;
        end

    // Load-use bubble is a single cycle
    assert property (@(posedge i_clk) disable iff (i_reset)
        i_load_stall |=> !i_load_stall)
        else begin
            $error("load-use stall lasted two cycles");
            fail_count++;
        end

endmodule

bind rv_core rv_core_sva i_rv_core_sva (
    .i_clk(i_clk),
    .i_reset(i_reset),
    .i_retire(o_retire),
    .i_load_stall(pc_stall)
);

// ==== rv_core.sv ====
`timescale 1ns/1ns
`include "rv_consts.svh"

module rv_core (
    input  logic                  i_clk,
    input  logic                  i_reset,
    input  rv_pipe_pkg::prog_wr_t i_prog,
    output rv_pipe_pkg::retire_t  o_retire
);
    import rv_pipe_pkg::*;

    localparam int IMEM_AW = $clog2(`RV_IMEM_WORDS);
    localparam int DMEM_AW = $clog2(`RV_DMEM_WORDS);

    typedef struct packed {
        logic                valid;
        logic [`RV_XLEN-1:0] pc;
        logic [`RV_XLEN-1:0] instr;
    } if_id_t;

    logic pc_stall;
    logic if_id_stall;
    logic if_id_flush;
    logic id_ex_flush;
    logic redirect;
    logic [`RV_XLEN-1:0] target;
    fwd_sel_e fwd_a;
    fwd_sel_e fwd_b;

    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] imem [`RV_IMEM_WORDS];
    logic [`RV_XLEN-1:0] dmem [`RV_DMEM_WORDS];
    logic [DMEM_AW-1:0]  dmem_addr;

    if_id_t  if_id_d;
    if_id_t  if_id_q;
    id_ex_t  id_ex_d;
    id_ex_t  id_ex_q;
    ex_mem_t ex_mem_d;
    ex_mem_t ex_mem_q;
    mem_wb_t mem_wb_d;
    mem_wb_t mem_wb_q;

    ctrl_t               id_ctrl;
    logic [`RV_XLEN-1:0] id_imm;
    logic [`RV_XLEN-1:0] id_rs1_data;
    logic [`RV_XLEN-1:0] id_rs2_data;
    logic [`RV_XLEN-1:0] wb_data;
    logic                wb_wren;

    ////////////////////
    // IF
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            pc <= `RV_RESET_PC;
        end else if (redirect) begin
            pc <= target;   // Resolved in EX
        end else if (!pc_stall) begin
            pc <= pc + `RV_XLEN'd4;
        end
    end

    // Program load only while reset is held
    always_ff @(posedge i_clk) begin
        if (i_reset && i_prog.valid) begin
            imem[i_prog.addr] <= i_prog.instr;
        end
    end

    assign if_id_d = '{valid: 1'b1, pc: pc, instr: imem[pc[IMEM_AW+1:2]]};

    rv_stage_reg #(.T(if_id_t)) i_if_id (
        .i_clk(i_clk), .i_reset(i_reset), .i_stall(if_id_stall), .i_flush(if_id_flush),
        .i_d(if_id_d), .o_q(if_id_q)
    );

    ////////////////////
    // ID
    rv_decoder i_decoder (.i_instr(if_id_q.instr), .o_ctrl(id_ctrl), .o_imm(id_imm));

    rv_regfile i_regfile (
        .i_clk(i_clk),
        .i_reset(i_reset),
        .i_rs1(if_id_q.instr[19:15]),
        .i_rs2(if_id_q.instr[24:20]),
        .i_rd(mem_wb_q.rd),
        .i_rd_wren(wb_wren),
        .i_rd_data(wb_data),
        .o_rs1_data(id_rs1_data),
        .o_rs2_data(id_rs2_data)
    );

    assign id_ex_d = '{
        valid:    if_id_q.valid,
        pc:       if_id_q.pc,
        rs1_data: id_rs1_data,
        rs2_data: id_rs2_data,
        rs1:      if_id_q.instr[19:15],
        rs2:      if_id_q.instr[24:20],
        rd:       if_id_q.instr[11:7],
        imm:      id_imm,
        ctrl:     id_ctrl
    };

    rv_hazard_unit i_hazard_unit (
        .i_id_ex(id_ex_q), .i_ex_mem(ex_mem_q), .i_mem_wb(mem_wb_q),
        .i_id_rs1(if_id_q.instr[19:15]), .i_id_rs2(if_id_q.instr[24:20]),
        .i_redirect(redirect),
        .o_pc_stall(pc_stall), .o_if_id_stall(if_id_stall),
        .o_if_id_flush(if_id_flush), .o_id_ex_flush(id_ex_flush),
        .o_fwd_a(fwd_a), .o_fwd_b(fwd_b)
    );

    rv_stage_reg #(.T(id_ex_t)) i_id_ex (
        .i_clk(i_clk), .i_reset(i_reset), .i_stall(1'b0), .i_flush(id_ex_flush),
        .i_d(id_ex_d), .o_q(id_ex_q)
    );

    ////////////////////
    // EX
    rv_execute i_execute (
        .i_id_ex(id_ex_q), .i_fwd_a(fwd_a), .i_fwd_b(fwd_b),
        .i_mem_result(ex_mem_q.result), .i_wb_data(wb_data),
        .o_ex_mem(ex_mem_d), .o_redirect(redirect), .o_target(target)
    );

    rv_stage_reg #(.T(ex_mem_t)) i_ex_mem (
        .i_clk(i_clk), .i_reset(i_reset), .i_stall(1'b0), .i_flush(1'b0),
        .i_d(ex_mem_d), .o_q(ex_mem_q)
    );

    ////////////////////
    // MEM with word-addressed data memory
    assign dmem_addr = ex_mem_q.result[DMEM_AW+1:2];

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            for (int i = 0; i < `RV_DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (ex_mem_q.valid && ex_mem_q.mem_wr) begin
            dmem[dmem_addr] <= ex_mem_q.store_data;
        end
    end

    assign mem_wb_d = '{
        valid:     ex_mem_q.valid,
        pc:        ex_mem_q.pc,
        result:    ex_mem_q.result,
        load_data: dmem[dmem_addr],
        rd:        ex_mem_q.rd,
        reg_wr:    ex_mem_q.reg_wr,
        load:      ex_mem_q.wb_sel == WB_LOAD
    };

    rv_stage_reg #(.T(mem_wb_t)) i_mem_wb (
        .i_clk(i_clk), .i_reset(i_reset), .i_stall(1'b0), .i_flush(1'b0),
        .i_d(mem_wb_d), .o_q(mem_wb_q)
    );

    ////////////////////
    // WB and retirement
    assign wb_data = mem_wb_q.load ? mem_wb_q.load_data : mem_wb_q.result;
    assign wb_wren = mem_wb_q.valid && mem_wb_q.reg_wr;

    assign o_retire = '{
        valid:   mem_wb_q.valid,
        pc:      mem_wb_q.pc,
        rd_wren: wb_wren,
        rd:      mem_wb_q.rd,
        rd_data: wb_data
    };

endmodule

// ==== rv_execute.sv ====
`timescale 1ns/1ns
`include "rv_consts.svh"

module rv_execute (
    input  rv_pipe_pkg::id_ex_t   i_id_ex,
    input  rv_pipe_pkg::fwd_sel_e i_fwd_a,
    input  rv_pipe_pkg::fwd_sel_e i_fwd_b,
    input  logic [`RV_XLEN-1:0]   i_mem_result,
    input  logic [`RV_XLEN-1:0]   i_wb_data,
    output rv_pipe_pkg::ex_mem_t  o_ex_mem,
    output logic                  o_redirect,
    output logic [`RV_XLEN-1:0]   o_target
);
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    ctrl_t               ctrl;
    logic [`RV_XLEN-1:0] rs1_val;
    logic [`RV_XLEN-1:0] rs2_val;
    logic [`RV_XLEN-1:0] op_a;
    logic [`RV_XLEN-1:0] op_b;
    logic [`RV_XLEN-1:0] alu_out;
    logic [`RV_XLEN-1:0] pc_plus4;
    logic                br_true;

    assign ctrl = i_id_ex.ctrl;

    // Forward muxes
    assign rs1_val = (i_fwd_a == FWD_MEM) ? i_mem_result :
                     (i_fwd_a == FWD_WB)  ? i_wb_data : i_id_ex.rs1_data;
    assign rs2_val = (i_fwd_b == FWD_MEM) ? i_mem_result :
                     (i_fwd_b == FWD_WB)  ? i_wb_data : i_id_ex.rs2_data;

    assign op_a     = ctrl.op_a_pc  ? i_id_ex.pc  : rs1_val;
    assign op_b     = ctrl.op_b_imm ? i_id_ex.imm : rs2_val;
    assign pc_plus4 = i_id_ex.pc + `RV_XLEN'd4;

    always_comb begin
        case (ctrl.alu_op)
            ALU_SUB:    alu_out = op_a - op_b;
            ALU_SLL:    alu_out = op_a << op_b[4:0];
            ALU_SLT:    alu_out = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   alu_out = {{(`RV_XLEN-1){1'b0}}, op_a < op_b};
            ALU_XOR:    alu_out = op_a ^ op_b;
            ALU_SRL:    alu_out = op_a >> op_b[4:0];
            ALU_SRA:    alu_out = $signed(op_a) >>> op_b[4:0];
            ALU_OR:     alu_out = op_a | op_b;
            ALU_AND:    alu_out = op_a & op_b;
            ALU_PASS_B: alu_out = op_b;
            default:    alu_out = op_a + op_b;
        endcase
    end

    always_comb begin
        case (ctrl.br_cond)
            BR_EQ:   br_true = rs1_val == rs2_val;
            BR_NE:   br_true = rs1_val != rs2_val;
            BR_LT:   br_true = $signed(rs1_val) <  $signed(rs2_val);
            BR_GE:   br_true = $signed(rs1_val) >= $signed(rs2_val);
            BR_LTU:  br_true = rs1_val <  rs2_val;
            BR_GEU:  br_true = rs1_val >= rs2_val;
            default: br_true = 1'b0;
        endcase
    end

    ////////////////////
    // Redirect against the not-taken prediction
    assign o_redirect = i_id_ex.valid && (ctrl.is_jump || (ctrl.is_branch && br_true));
    assign o_target   = ctrl.is_branch ? i_id_ex.pc + i_id_ex.imm
                                       : {alu_out[`RV_XLEN-1:1], 1'b0}; // JAL and JALR

    assign o_ex_mem = '{
        valid:      i_id_ex.valid,
        pc:         i_id_ex.pc,
        result:     (ctrl.wb_sel == WB_PC4) ? pc_plus4 : alu_out,
        store_data: rs2_val,
        rd:         i_id_ex.rd,
        mem_wr:     ctrl.mem_wr,
        mem_rd:     ctrl.mem_rd,
        reg_wr:     ctrl.reg_wr,
        wb_sel:     ctrl.wb_sel
    };

endmodule

// ==== rv_hazard_unit.sv ====
`timescale 1ns/1ns
`include "rv_consts.svh"

module rv_hazard_unit (
    input  rv_pipe_pkg::id_ex_t   i_id_ex,
    input  rv_pipe_pkg::ex_mem_t  i_ex_mem,
    input  rv_pipe_pkg::mem_wb_t  i_mem_wb,
    input  logic [`RV_REG_AW-1:0] i_id_rs1,
    input  logic [`RV_REG_AW-1:0] i_id_rs2,
    input  logic                  i_redirect,
    output logic                  o_pc_stall,
    output logic                  o_if_id_stall,
    output logic                  o_if_id_flush,
    output logic                  o_id_ex_flush,
    output rv_pipe_pkg::fwd_sel_e o_fwd_a,
    output rv_pipe_pkg::fwd_sel_e o_fwd_b
);
    import rv_pipe_pkg::*;

    logic load_use;

    // Load in EX feeding the instruction in ID
    assign load_use = i_id_ex.valid && i_id_ex.ctrl.mem_rd && i_id_ex.rd != '0 &&
                      (i_id_ex.rd == i_id_rs1 || i_id_ex.rd == i_id_rs2);

    assign o_pc_stall    = load_use;
    assign o_if_id_stall = load_use;
    assign o_if_id_flush = i_redirect;
    assign o_id_ex_flush = load_use || i_redirect; // Bubble or wrong-path slot

    // MEM wins over WB and a load in MEM has no data yet
    function automatic fwd_sel_e pick_src(
        input logic [`RV_REG_AW-1:0] rs,
        input ex_mem_t               ex_mem,
        input mem_wb_t               mem_wb
    );
        if (rs == '0) return FWD_RF;
        if (ex_mem.valid && ex_mem.reg_wr && !ex_mem.mem_rd && ex_mem.rd == rs)
            return FWD_MEM;
        if (mem_wb.valid && mem_wb.reg_wr && mem_wb.rd == rs) return FWD_WB;
        return FWD_RF;
    endfunction

    assign o_fwd_a = pick_src(i_id_ex.rs1, i_ex_mem, i_mem_wb);
    assign o_fwd_b = pick_src(i_id_ex.rs2, i_ex_mem, i_mem_wb);

endmodule

// ==== rv_decoder.sv ====
`timescale 1ns/1ns
`include "rv_consts.svh"

module rv_decoder (
    input  logic [`RV_XLEN-1:0] i_instr,
    output rv_pipe_pkg::ctrl_t  o_ctrl,
    output logic [`RV_XLEN-1:0] o_imm
);
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    opcode_e    opcode;
    logic [2:0] funct3;
    imm_sel_e   imm_sel;

    assign opcode = opcode_e'(i_instr[6:0]);
    assign funct3 = i_instr[14:12];

    always_comb begin
        o_ctrl        = '0;
        o_ctrl.alu_op = ALU_ADD;
        o_ctrl.wb_sel = WB_ALU;
        imm_sel       = IMM_I;
        case (opcode)
            OP_LUI: begin
                imm_sel         = IMM_U;
                o_ctrl.op_b_imm = 1'b1;
                o_ctrl.alu_op   = ALU_PASS_B;
                o_ctrl.reg_wr   = 1'b1;
            end
            OP_AUIPC: begin
                imm_sel         = IMM_U;
                o_ctrl.op_a_pc  = 1'b1;
                o_ctrl.op_b_imm = 1'b1;
                o_ctrl.reg_wr   = 1'b1;
            end
            OP_JAL: begin // Target is pc + imm from the ALU
                imm_sel         = IMM_J;
                o_ctrl.op_a_pc  = 1'b1;
                o_ctrl.op_b_imm = 1'b1;
                o_ctrl.is_jump  = 1'b1;
                o_ctrl.reg_wr   = 1'b1;
                o_ctrl.wb_sel   = WB_PC4;
            end
            OP_JALR: begin
                o_ctrl.op_b_imm = 1'b1;
                o_ctrl.is_jump  = 1'b1;
                o_ctrl.reg_wr   = 1'b1;
                o_ctrl.wb_sel   = WB_PC4;
            end
            OP_BRANCH: begin
                imm_sel          = IMM_B;
                o_ctrl.is_branch = 1'b1;
                o_ctrl.br_cond   = br_cond_e'(funct3);
            end
            OP_LOAD: begin
                o_ctrl.op_b_imm = 1'b1;
                o_ctrl.mem_rd   = 1'b1;
                o_ctrl.reg_wr   = 1'b1;
                o_ctrl.wb_sel   = WB_LOAD;
            end
            OP_STORE: begin
                imm_sel         = IMM_S;
                o_ctrl.op_b_imm = 1'b1;
                o_ctrl.mem_wr   = 1'b1;
            end
            OP_IMM: begin
                // instr[30] only selects srai and is immediate elsewhere
                o_ctrl.op_b_imm = 1'b1;
                o_ctrl.alu_op   = alu_op_e'({(funct3 == 3'b101) & i_instr[30], funct3});
                o_ctrl.reg_wr   = 1'b1;
            end
            OP_REG: begin
                o_ctrl.alu_op = alu_op_e'({i_instr[30], funct3});
                o_ctrl.reg_wr = 1'b1;
            end
            default: ; // Unknown opcode stays a no-op
        endcase
        o_ctrl.reg_wr = o_ctrl.reg_wr && (i_instr[11:7] != '0); // x0 never written
    end

    ////////////////////
    // Immediate generation
    always_comb begin
        case (imm_sel)
            IMM_S:   o_imm = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
            IMM_B:   o_imm = {{19{i_instr[31]}}, i_instr[31], i_instr[7],
                              i_instr[30:25], i_instr[11:8], 1'b0};
            IMM_U:   o_imm = {i_instr[31:12], 12'b0};
            IMM_J:   o_imm = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12],
                              i_instr[20], i_instr[30:21], 1'b0};
            default: o_imm = {{20{i_instr[31]}}, i_instr[31:20]};
        endcase
    end

endmodule

// ==== rv_regfile.sv ====
`timescale 1ns/1ns
`include "rv_consts.svh"

module rv_regfile (
    input  logic                  i_clk,
    input  logic                  i_reset,
    input  logic [`RV_REG_AW-1:0] i_rs1,
    input  logic [`RV_REG_AW-1:0] i_rs2,
    input  logic [`RV_REG_AW-1:0] i_rd,
    input  logic                  i_rd_wren,
    input  logic [`RV_XLEN-1:0]   i_rd_data,
    output logic [`RV_XLEN-1:0]   o_rs1_data,
    output logic [`RV_XLEN-1:0]   o_rs2_data
);

    logic [`RV_XLEN-1:0] regs [1:31]; // x0 is not stored

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_rd_wren && i_rd != '0) begin
            regs[i_rd] <= i_rd_data;
        end
    end

    // Same-cycle write is bypassed to the read ports
    assign o_rs1_data = (i_rs1 == '0)                ? '0        :
                        (i_rd_wren && i_rs1 == i_rd) ? i_rd_data : regs[i_rs1];
    assign o_rs2_data = (i_rs2 == '0)                ? '0        :
                        (i_rd_wren && i_rs2 == i_rd) ? i_rd_data : regs[i_rs2];

endmodule

// ==== rv_stage_reg.sv ====
`timescale 1ns/1ns

module rv_stage_reg #(
    parameter type T = logic
) (
    input  logic i_clk,
    input  logic i_reset,
    input  logic i_stall,
    input  logic i_flush,
    input  T     i_d,
    output T     o_q
);

    // All zeros is a bubble with the valid bit cleared
    always_ff @(posedge i_clk) begin
        if (i_reset || i_flush) begin
            o_q <= '0;
        end else if (!i_stall) begin
            o_q <= i_d;
        end
    end

endmodule

// ==== rv_pipe_pkg.sv ====
`include "rv_consts.svh"

package rv_pipe_pkg;

    typedef enum logic [1:0] {
        WB_ALU  = 2'd0,
        WB_LOAD = 2'd1,
        WB_PC4  = 2'd2
    } wb_sel_e;

    // Operand source in EX
    typedef enum logic [1:0] {
        FWD_RF  = 2'd0,
        FWD_MEM = 2'd1,
        FWD_WB  = 2'd2
    } fwd_sel_e;

    typedef struct packed {
        rv_isa_pkg::alu_op_e  alu_op;
        logic                 op_a_pc;   // Operand A is the PC
        logic                 op_b_imm;  // Operand B is the immediate
        logic                 is_branch;
        rv_isa_pkg::br_cond_e br_cond;
        logic                 is_jump;
        logic                 mem_wr;
        logic                 mem_rd;
        logic                 reg_wr;
        wb_sel_e              wb_sel;
    } ctrl_t;

    typedef struct packed {
        logic                   valid;
        logic [`RV_XLEN-1:0]    pc;
        logic [`RV_XLEN-1:0]    rs1_data;
        logic [`RV_XLEN-1:0]    rs2_data;
        logic [`RV_REG_AW-1:0]  rs1;
        logic [`RV_REG_AW-1:0]  rs2;
        logic [`RV_REG_AW-1:0]  rd;
        logic [`RV_XLEN-1:0]    imm;
        ctrl_t                  ctrl;
    } id_ex_t;

    typedef struct packed {
        logic                   valid;
        logic [`RV_XLEN-1:0]    pc;
        logic [`RV_XLEN-1:0]    result;     // ALU result or PC+4
        logic [`RV_XLEN-1:0]    store_data;
        logic [`RV_REG_AW-1:0]  rd;
        logic                   mem_wr;
        logic                   mem_rd;
        logic                   reg_wr;
        wb_sel_e                wb_sel;
    } ex_mem_t;

    typedef struct packed {
        logic                   valid;
        logic [`RV_XLEN-1:0]    pc;
        logic [`RV_XLEN-1:0]    result;
        logic [`RV_XLEN-1:0]    load_data;
        logic [`RV_REG_AW-1:0]  rd;
        logic                   reg_wr;
        logic                   load;
    } mem_wb_t;

    // One record per completed instruction
    typedef struct packed {
        logic                   valid;
        logic [`RV_XLEN-1:0]    pc;
        logic                   rd_wren;
        logic [`RV_REG_AW-1:0]  rd;
        logic [`RV_XLEN-1:0]    rd_data;
    } retire_t;

    typedef struct packed {
        logic                              valid;
        logic [$clog2(`RV_IMEM_WORDS)-1:0] addr;  // Word address
        logic [`RV_XLEN-1:0]               instr;
    } prog_wr_t;

endpackage

// ==== rv_isa_pkg.sv ====
package rv_isa_pkg;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011
    } opcode_e;

    // Low three bits follow funct3 and bit 3 is instr[30]
    typedef enum logic [3:0] {
        ALU_ADD    = 4'b0000,
        ALU_SLL    = 4'b0001,
        ALU_SLT    = 4'b0010,
        ALU_SLTU   = 4'b0011,
        ALU_XOR    = 4'b0100,
        ALU_SRL    = 4'b0101,
        ALU_OR     = 4'b0110,
        ALU_AND    = 4'b0111,
        ALU_SUB    = 4'b1000,
        ALU_SRA    = 4'b1101,
        ALU_PASS_B = 4'b1111  // LUI
    } alu_op_e;

    typedef enum logic [2:0] {
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J
    } imm_sel_e;

    // Branch funct3 encodings
    typedef enum logic [2:0] {
        BR_EQ  = 3'b000,
        BR_NE  = 3'b001,
        BR_LT  = 3'b100,
        BR_GE  = 3'b101,
        BR_LTU = 3'b110,
        BR_GEU = 3'b111
    } br_cond_e;

endpackage

// ==== rv_consts.svh ====
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// Datapath and register index widths
`define RV_XLEN   32
`define RV_REG_AW 5

// Memory depths in 32-bit words
`define RV_IMEM_WORDS 256
`define RV_DMEM_WORDS 256

`define RV_RESET_PC 32'h0000_0000 // First fetch address

`endif
